//--- source/apb_bridge_config.svh
// widths are fixed at build time; the register count must stay a power of two for the index decode
`ifndef APB_BRIDGE_CONFIG_SVH
`define APB_BRIDGE_CONFIG_SVH

// byte address width seen by the master and the register bank
// only bits 4 to 2 select a register, everything above bit 4 must be zero
`define APB_ADDR_WIDTH 12

// data path width, one register is one full word
`define APB_DATA_WIDTH 32

// number of registers in the bank
// index 0 holds the wait-state setting and index 1 the write counter
// all indices above 1 are plain scratch storage
`define APB_REG_COUNT 8

// width of the programmable wait-state value
// it is taken from the low bits of register 0, so up to seven wait cycles
`define APB_WAIT_WIDTH 3

`endif

//--- source/apb_bridge_pkg.sv
// shared types of the bridge; widths come from the config header and are not meant to be overridden
`include "apb_bridge_config.svh"

package apb_bridge_pkg;

    // byte address and data word of one transfer
    typedef logic [`APB_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`APB_DATA_WIDTH-1:0] data_t;

    // the word index sits right above the two byte-offset bits
    localparam int IDX_WIDTH = $clog2(`APB_REG_COUNT);
    localparam int IDX_LSB   = 2;

    // register index as decoded from the address
    typedef logic [IDX_WIDTH-1:0] idx_t;

    // number of wait cycles inserted into each access
    typedef logic [`APB_WAIT_WIDTH-1:0] wait_t;

    // the write counter wraps at this width, upper bits of register 1 read as zero
    localparam int WCOUNT_WIDTH = 16;

    // fixed roles of the two special registers
    localparam idx_t REG_WAIT   = idx_t'(0);
    localparam idx_t REG_WCOUNT = idx_t'(1);

    // two-phase APB state, idle and setup share the SETUP encoding
    typedef enum logic {
        SETUP  = 1'b0,
        ACCESS = 1'b1
    } phase_e;

endpackage

//--- source/apb_phase_fsm.sv
// expects the master to hold psel, penable and payload steady until pready; one transfer in flight
`timescale 1ns/10ps

module apb_phase_fsm (
    input  logic                  clk_i,
    input  logic                  rst_n,

    // single-cycle style request from the upstream master
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  apb_bridge_pkg::addr_t paddr_i,
    input  apb_bridge_pkg::data_t pwdata_i,

    // end of access, coming from the wait timer
    input  logic                  pready_i,

    // compliant two-phase transfer towards the register bank
    output logic                  psel_o,
    output logic                  penable_o,
    output logic                  pwrite_o,
    output apb_bridge_pkg::addr_t paddr_o,
    output apb_bridge_pkg::data_t pwdata_o,

    // one-cycle pulse in the setup cycle of an accepted request
    output logic                  setup_fire_o
);

    import apb_bridge_pkg::*;

    phase_e state_q;
    phase_e state_d;
    logic   req;

    // the upstream master raises both strobes together, so either alone means nothing
    assign req = psel_i & penable_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            SETUP: begin
                if (req) begin
                    state_d = ACCESS;
                end
            end
            ACCESS: begin
                // wait states are handled entirely by the timer
                if (pready_i) begin
                    state_d = SETUP;
                end
            end
            default: state_d = SETUP;
        endcase
    end

    // select follows the request directly, enable marks the access phase only
    assign psel_o       = req;
    assign penable_o    = (state_q == ACCESS);
    assign setup_fire_o = req && (state_q == SETUP);

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= SETUP;
            paddr_o  <= '0;
            pwrite_o <= 1'b0;
            pwdata_o <= '0;
        end else begin
            state_q <= state_d;
            // the payload is frozen for the whole access from here on
            if (setup_fire_o) begin
                paddr_o  <= paddr_i;
                pwrite_o <= pwrite_i;
                // read requests leave the last write data in place
                if (pwrite_i) begin
                    pwdata_o <= pwdata_i;
                end
            end
        end
    end

    // the access phase is only legal while the master still holds the request
    assert property (@(posedge clk_i) disable iff (!rst_n)
        penable_o |-> psel_o);

    // the timer must never finish a transfer this FSM has not started
    assert property (@(posedge clk_i) disable iff (!rst_n)
        pready_i |-> (state_q == ACCESS));

endmodule

//--- source/apb_wait_timer.sv
// the wait value is sampled only at start, so a later change of the config affects the next access
`timescale 1ns/10ps
`include "apb_bridge_config.svh"

module apb_wait_timer (
    input  logic                  clk_i,
    input  logic                  rst_n,

    // setup cycle of a new transfer
    input  logic                  start_i,

    // programmed number of wait states
    input  apb_bridge_pkg::wait_t wait_cfg_i,

    // one-cycle strobe that closes the access
    output logic                  pready_o
);

    import apb_bridge_pkg::*;

    wait_t count_q;
    logic  busy_q;

    // the first access cycle already sees the loaded value, so W waits give 1 + W access cycles
    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
            busy_q  <= 1'b0;
        end else begin
            if (start_i) begin
                count_q <= wait_cfg_i;
                busy_q  <= 1'b1;
            end else if (busy_q) begin
                if (count_q == '0) begin
                    // pready is high in this cycle, the transfer ends here
                    busy_q <= 1'b0;
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end
        end
    end

    // ready is a pure function of the counter, never held past one cycle
    assign pready_o = busy_q && (count_q == '0);

    // the FSM may not start a second transfer before the first has ended
    assert property (@(posedge clk_i) disable iff (!rst_n)
        start_i |-> !busy_q);

    // an idle timer must stay silent
    assert property (@(posedge clk_i) disable iff (!rst_n)
        pready_o |-> busy_q);

    // each started access ends within the largest programmable wait
    assert property (@(posedge clk_i) disable iff (!rst_n)
        start_i |=> ##[0:(2**`APB_WAIT_WIDTH)-1] pready_o);

endmodule

//--- source/apb_reg_bank.sv
// no byte strobes; writes are whole words and register 1 is read-only, out-of-range indices give pslverr
`timescale 1ns/10ps
`include "apb_bridge_config.svh"

module apb_reg_bank (
    input  logic                  clk_i,
    input  logic                  rst_n,

    // two-phase transfer from the phase FSM
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  apb_bridge_pkg::addr_t paddr_i,
    input  apb_bridge_pkg::data_t pwdata_i,

    // last access cycle, from the wait timer
    input  logic                  pready_i,

    // response, valid together with pready
    output apb_bridge_pkg::data_t prdata_o,
    output logic                  pslverr_o,

    // current wait-state setting for the timer
    output apb_bridge_pkg::wait_t wait_cfg_o
);

    import apb_bridge_pkg::*;

    data_t                   regs_q [`APB_REG_COUNT];
    idx_t                    idx;
    logic                    addr_err;
    logic                    done;
    logic                    wr_commit;
    logic [WCOUNT_WIDTH-1:0] wcount_next;

    // word index from bits 4 to 2, the byte offset bits are ignored
    assign idx = paddr_i[IDX_LSB +: IDX_WIDTH];

    // any set bit above the index field points past the eighth register
    assign addr_err = |paddr_i[`APB_ADDR_WIDTH-1:IDX_LSB+IDX_WIDTH];

    // the last access cycle, the only one in which anything is committed or returned
    assign done = psel_i & penable_i & pready_i;

    // writes outside the bank are dropped here and answered with an error
    assign wr_commit = done & pwrite_i & ~addr_err;

    // the counter lives in the low bits of register 1 and wraps on overflow
    assign wcount_next = regs_q[REG_WCOUNT][WCOUNT_WIDTH-1:0] + 1'b1;

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `APB_REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_commit) begin
            // register 1 belongs to the counter, writes to it are silently ignored
            if (idx != REG_WCOUNT) begin
                regs_q[idx]        <= pwdata_i;
                regs_q[REG_WCOUNT] <= data_t'(wcount_next);
            end
        end
    end

    // read data is driven only in the completing cycle of a valid read
    always_comb begin
        prdata_o = '0;
        if (done && !pwrite_i && !addr_err) begin
            prdata_o = regs_q[idx];
        end
    end

    // error strobe coincides with pready for reads and writes alike
    assign pslverr_o = done & addr_err;

    // the timer samples this at the next setup, so a new value applies to the next transfer
    assign wait_cfg_o = regs_q[REG_WAIT][`APB_WAIT_WIDTH-1:0];

    // an error response is only ever given as the end of an access
    assert property (@(posedge clk_i) disable iff (!rst_n)
        pslverr_o |-> (pready_i && penable_i));

endmodule

//--- source/apb_bridge_top.sv
// one upstream master and one register bank; the master must hold its request until pready_o
`timescale 1ns/10ps

module apb_bridge_top (
    input  logic                  clk_i,
    input  logic                  rst_n,

    // upstream request, psel and penable rise together
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  apb_bridge_pkg::addr_t paddr_i,
    input  apb_bridge_pkg::data_t pwdata_i,

    // response straight from the bank and the timer
    output apb_bridge_pkg::data_t prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o
);

    import apb_bridge_pkg::*;

    // converted transfer between the FSM and the bank
    logic  apb_psel;
    logic  apb_penable;
    logic  apb_pwrite;
    addr_t apb_paddr;
    data_t apb_pwdata;

    // timing control
    logic  setup_fire;
    logic  pready;
    wait_t wait_cfg;

    apb_phase_fsm u_phase_fsm (
        .clk_i        (clk_i),
        .rst_n        (rst_n),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .pready_i     (pready),
        .psel_o       (apb_psel),
        .penable_o    (apb_penable),
        .pwrite_o     (apb_pwrite),
        .paddr_o      (apb_paddr),
        .pwdata_o     (apb_pwdata),
        .setup_fire_o (setup_fire)
    );

    apb_wait_timer u_wait_timer (
        .clk_i      (clk_i),
        .rst_n      (rst_n),
        .start_i    (setup_fire),
        .wait_cfg_i (wait_cfg),
        .pready_o   (pready)
    );

    apb_reg_bank u_reg_bank (
        .clk_i      (clk_i),
        .rst_n      (rst_n),
        .psel_i     (apb_psel),
        .penable_i  (apb_penable),
        .pwrite_i   (apb_pwrite),
        .paddr_i    (apb_paddr),
        .pwdata_i   (apb_pwdata),
        .pready_i   (pready),
        .prdata_o   (prdata_o),
        .pslverr_o  (pslverr_o),
        .wait_cfg_o (wait_cfg)
    );

    // the timer strobe doubles as the upstream ready
    assign pready_o = pready;

endmodule

//--- verif/tb_clock_gen.sv
// free-running 10 ns clock; reset is held low for the first 8 rising edges and released 1 ns later
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // half period of 5 ns gives the 10 ns clock
    initial begin
        clk_o = 1'b0;
    end

    always #5 clk_o = ~clk_o;

    // release lines up with the stimulus, which also moves 1 ns after the edge
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

//--- verif/tb_apb_bridge.sv
// single master, one transfer at a time; stimulus comes from a fixed-seed LFSR, so every run is the same
`timescale 1ns/10ps
`include "apb_bridge_config.svh"

module tb_apb_bridge;

    import apb_bridge_pkg::*;

    // longest wait for pready_o, well above the 1 + 7 cycles of the slowest access
    localparam int READY_TIMEOUT = 20;

    logic  clk_i;
    logic  rst_n;
    logic  psel_i;
    logic  penable_i;
    logic  pwrite_i;
    addr_t paddr_i;
    data_t pwdata_i;
    data_t prdata_o;
    logic  pready_o;
    logic  pslverr_o;

    // reference model of the bank
    data_t       model_regs [`APB_REG_COUNT];
    wait_t       model_wait;
    logic [15:0] model_wcount;

    logic [31:0] lfsr;
    int          data_errors;
    int          flag_errors;
    int          cycle_errors;
    int          timeouts;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk_i),
        .rst_n_o (rst_n)
    );

    apb_bridge_top u_dut (
        .clk_i     (clk_i),
        .rst_n     (rst_n),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o)
    );

    // fibonacci LFSR with taps 32, 22, 2 and 1, a maximal-length sequence
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    // one LFSR step per bit, the new bit is shifted in from the right
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_cycles(input string name, input integer got, input integer exp);
        if (got !== exp) begin
            cycle_errors++;
            $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // entered and left 1 ns after a rising edge, with the request dropped on the way out
    task automatic transfer(input logic wr, input int idx, input data_t wdata);
        data_t  exp_rdata;
        logic   exp_err;
        integer exp_cycles;
        integer cycles;
        logic   seen;
        if (timeouts != 0) begin
            return;
        end
        // expectations come from the model state before this transfer
        exp_err    = (idx >= `APB_REG_COUNT);
        exp_cycles = 1 + integer'(model_wait);
        exp_rdata  = '0;
        if (!wr && !exp_err) begin
            exp_rdata = model_regs[idx];
        end
        psel_i    = 1'b1;
        penable_i = 1'b1;
        pwrite_i  = wr;
        paddr_i   = addr_t'(idx * 4);
        pwdata_i  = wdata;
        // the first falling edge is cycle 0, sampled where the outputs have settled
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < READY_TIMEOUT) begin
            @(negedge clk_i);
            if (pready_o) begin
                seen = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (!seen) begin
            timeouts++;
            $display("transfer to index %0d got no pready_o within %0d cycles", idx,
                     READY_TIMEOUT);
            @(posedge clk_i);
            #1;
            psel_i    = 1'b0;
            penable_i = 1'b0;
            return;
        end
        check_cycles("pready_o latency", cycles, exp_cycles);
        check_flag("pslverr_o", pslverr_o, exp_err);
        check_data("prdata_o", prdata_o, exp_rdata);
        // the request is held through the ready cycle so the bank can commit
        @(posedge clk_i);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        // register 1 ignores writes and out-of-range writes change nothing
        if (wr && !exp_err && idx != 1) begin
            model_regs[idx] = wdata;
            model_wcount    = model_wcount + 16'd1;
            model_regs[1]   = data_t'(model_wcount);
            if (idx == 0) begin
                model_wait = wdata[`APB_WAIT_WIDTH-1:0];
            end
        end
    endtask

    task automatic idle(input int gap);
        for (int k = 0; k < gap; k++) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // direction, index 0 to 9, data and a gap of 0 to 3 cycles, in that order
    task automatic random_transfer();
        logic  wr;
        int    idx;
        data_t data;
        int    gap;
        wr   = (random_bits(1) != 32'd0);
        idx  = int'(random_bits(4)) % 10;
        data = random_bits(32);
        gap  = int'(random_bits(2));
        transfer(wr, idx, data);
        idle(gap);
    endtask

    task automatic finish_run();
        $display("errors: data %0d, flag %0d, cycles %0d, timeouts %0d",
                 data_errors, flag_errors, cycle_errors, timeouts);
        if (data_errors + flag_errors + cycle_errors + timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    initial begin
        int    rst_wait;
        data_t wdata;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        paddr_i      = '0;
        pwdata_i     = '0;
        lfsr         = 32'heb80_7b56;
        model_wait   = '0;
        model_wcount = '0;
        data_errors  = 0;
        flag_errors  = 0;
        cycle_errors = 0;
        timeouts     = 0;
        for (int i = 0; i < `APB_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end

        // reset may still be unknown at time zero, so wait for a clean release
        rst_wait = 0;
        while (rst_n !== 1'b1 && rst_wait < 20) begin
            @(posedge clk_i);
            rst_wait++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("reset was still asserted after 20 cycles");
        end
        @(posedge clk_i);
        #1;

        // every register reads zero out of reset
        for (int i = 0; i < `APB_REG_COUNT; i++) begin
            transfer(1'b0, i, '0);
        end

        // write and read back one scratch register, then a random mix
        wdata = random_bits(32);
        transfer(1'b1, 3, wdata);
        transfer(1'b0, 3, '0);
        for (int n = 0; n < 60; n++) begin
            random_transfer();
        end

        // sweep the wait setting, random upper bits must not affect the latency
        for (int w = 0; w < 8; w++) begin
            wdata = (random_bits(32) & ~data_t'(7)) | data_t'(w);
            transfer(1'b1, 0, wdata);
            transfer(1'b0, 2 + (w % 6), '0);
            transfer(1'b1, 2 + ((w + 3) % 6), random_bits(32));
            idle(int'(random_bits(2)));
        end

        // the counter register is read-only
        transfer(1'b1, 1, random_bits(32));
        transfer(1'b0, 1, '0);
        transfer(1'b1, 5, random_bits(32));
        transfer(1'b0, 1, '0);

        // out-of-range accesses answer with an error and leave the bank alone
        transfer(1'b1, 8, random_bits(32));
        transfer(1'b0, 8, '0);
        transfer(1'b1, 9, random_bits(32));
        transfer(1'b0, 9, '0);
        for (int i = 0; i < `APB_REG_COUNT; i++) begin
            transfer(1'b0, i, '0);
        end

        finish_run();
    end

endmodule

//--- verilog.f
+incdir+source
source/apb_bridge_pkg.sv
source/apb_phase_fsm.sv
source/apb_wait_timer.sv
source/apb_reg_bank.sv
source/apb_bridge_top.sv
verif/tb_clock_gen.sv
verif/tb_apb_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot change to the project root"
    exit 1
fi

verilator --binary --timing --assert -f verilog.f --top-module tb_apb_bridge -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_apb_bridge)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the run counts as passed only if the testbench printed its pass line
printf '%s\n' "$sim_output" | grep -qx "Testbench passed"
if [ $? -ne 0 ]; then
    exit 1
fi
exit 0
